//--- verilog/soc_pkg.sv
// SoC package with bus widths, address map, response codes and graphics register map
package soc_pkg;

	// AXI-Lite bus geometry
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	localparam int PROT_WIDTH = 3;

	// Address map
	localparam logic [ADDR_WIDTH-1:0] MEM_BASE = 32'h0000_0000;
	localparam int MEM_ADDR_BITS = 16; // 64 KiB window
	localparam logic [ADDR_WIDTH-1:0] GFX_BASE = 32'h0200_0000;
	localparam int GFX_ADDR_BITS = 8;

	// Response codes
	localparam logic [1:0] RESP_OKAY = 2'd0;
	localparam logic [1:0] RESP_DECERR = 2'd3;

	// Graphics register byte offsets
	localparam logic [GFX_ADDR_BITS-1:0] REG_CTRL = 8'h00;
	localparam logic [GFX_ADDR_BITS-1:0] REG_FB_BASE = 8'h04;
	localparam logic [GFX_ADDR_BITS-1:0] REG_LINE_WORDS = 8'h08;
	localparam logic [GFX_ADDR_BITS-1:0] REG_FRAME_COUNT = 8'h0c; // read only

	localparam int CTRL_ENABLE_BIT = 0;

endpackage

//--- verilog/axil_if.sv
// AXI-Lite link carrying the AW, W, B, AR and R channels between a master and a slave
`timescale 1ns/1ps

interface axil_if;

	logic [soc_pkg::ADDR_WIDTH-1:0] awaddr;
	logic [soc_pkg::PROT_WIDTH-1:0] awprot;
	logic awvalid;
	logic awready;

	logic [soc_pkg::DATA_WIDTH-1:0] wdata;
	logic [soc_pkg::STRB_WIDTH-1:0] wstrb;
	logic wvalid;
	logic wready;

	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	logic [soc_pkg::ADDR_WIDTH-1:0] araddr;
	logic [soc_pkg::PROT_WIDTH-1:0] arprot;
	logic arvalid;
	logic arready;

	logic [soc_pkg::DATA_WIDTH-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	modport master (
		output awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
		output araddr, arprot, arvalid, rready,
		input awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

	modport slave (
		input awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready,
		input araddr, arprot, arvalid, rready,
		output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
	);

endinterface

//--- verilog/axil_interconnect.sv
// Shared AXI-Lite interconnect for two masters and two slaves, one transaction at a time
`timescale 1ns/1ps

module axil_interconnect (
	input logic hdmi_pixClk,
	input logic reset,
	axil_if.slave s0,
	axil_if.slave s1,
	axil_if.master m0,
	axil_if.master m1
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ = 2'd1;
	localparam logic [1:0] ST_RESP = 2'd2;

	logic [1:0] state;
	logic rr; // Master with priority on the next grant

	logic req0_wr, req0_rd, req1_wr, req1_rd;
	logic grant, win, win_wr;
	logic [soc_pkg::ADDR_WIDTH-1:0] win_addr;
	logic [soc_pkg::PROT_WIDTH-1:0] win_prot;
	logic hit_mem, hit_gfx;

	// Latched winning request
	logic [soc_pkg::ADDR_WIDTH-1:0] addr_q;
	logic [soc_pkg::PROT_WIDTH-1:0] prot_q;
	logic [soc_pkg::DATA_WIDTH-1:0] data_q;
	logic [soc_pkg::STRB_WIDTH-1:0] strb_q;
	logic wr_q, win_q, sel_q, decerr_q;

	logic aw_pend, w_pend, ar_pend;
	logic aw_hs, w_hs, ar_hs, req_left;

	logic resp_bvalid, resp_rvalid, win_bready, win_rready, resp_done;
	logic [1:0] resp_bresp, resp_rresp;
	logic [soc_pkg::DATA_WIDTH-1:0] resp_rdata;

	// Arbitration
	assign req0_wr = s0.awvalid & s0.wvalid;
	assign req0_rd = s0.arvalid;
	assign req1_wr = s1.awvalid & s1.wvalid;
	assign req1_rd = s1.arvalid;
	assign grant = (state == ST_IDLE) & (req0_wr | req0_rd | req1_wr | req1_rd);
	assign win = rr ? (req1_wr | req1_rd) : ~(req0_wr | req0_rd);
	assign win_wr = win ? req1_wr : req0_wr; // Write wins inside one master

	assign win_addr = win_wr ? (win ? s1.awaddr : s0.awaddr) : (win ? s1.araddr : s0.araddr);
	assign win_prot = win_wr ? (win ? s1.awprot : s0.awprot) : (win ? s1.arprot : s0.arprot);

	// Address decode
	assign hit_mem = (win_addr >> soc_pkg::MEM_ADDR_BITS) ==
		(soc_pkg::MEM_BASE >> soc_pkg::MEM_ADDR_BITS);
	assign hit_gfx = (win_addr >> soc_pkg::GFX_ADDR_BITS) ==
		(soc_pkg::GFX_BASE >> soc_pkg::GFX_ADDR_BITS);

	// Request accepted from the winner on the grant cycle
	assign s0.awready = grant & ~win & win_wr;
	assign s0.wready = grant & ~win & win_wr;
	assign s0.arready = grant & ~win & ~win_wr;
	assign s1.awready = grant & win & win_wr;
	assign s1.wready = grant & win & win_wr;
	assign s1.arready = grant & win & ~win_wr;

	// Forwarding to the decoded slave
	assign m0.awaddr = addr_q;
	assign m0.awprot = prot_q;
	assign m0.wdata = data_q;
	assign m0.wstrb = strb_q;
	assign m0.araddr = addr_q;
	assign m0.arprot = prot_q;
	assign m0.awvalid = (state == ST_REQ) & aw_pend & ~sel_q;
	assign m0.wvalid = (state == ST_REQ) & w_pend & ~sel_q;
	assign m0.arvalid = (state == ST_REQ) & ar_pend & ~sel_q;

	assign m1.awaddr = addr_q;
	assign m1.awprot = prot_q;
	assign m1.wdata = data_q;
	assign m1.wstrb = strb_q;
	assign m1.araddr = addr_q;
	assign m1.arprot = prot_q;
	assign m1.awvalid = (state == ST_REQ) & aw_pend & sel_q;
	assign m1.wvalid = (state == ST_REQ) & w_pend & sel_q;
	assign m1.arvalid = (state == ST_REQ) & ar_pend & sel_q;

	assign aw_hs = sel_q ? (m1.awvalid & m1.awready) : (m0.awvalid & m0.awready);
	assign w_hs = sel_q ? (m1.wvalid & m1.wready) : (m0.wvalid & m0.wready);
	assign ar_hs = sel_q ? (m1.arvalid & m1.arready) : (m0.arvalid & m0.arready);
	assign req_left = (aw_pend & ~aw_hs) | (w_pend & ~w_hs) | (ar_pend & ~ar_hs);

	// Response path, decode errors answered locally
	assign win_bready = win_q ? s1.bready : s0.bready;
	assign win_rready = win_q ? s1.rready : s0.rready;
	assign resp_bvalid = (state == ST_RESP) & wr_q &
		(decerr_q | (sel_q ? m1.bvalid : m0.bvalid));
	assign resp_rvalid = (state == ST_RESP) & ~wr_q &
		(decerr_q | (sel_q ? m1.rvalid : m0.rvalid));
	assign resp_bresp = decerr_q ? soc_pkg::RESP_DECERR : (sel_q ? m1.bresp : m0.bresp);
	assign resp_rresp = decerr_q ? soc_pkg::RESP_DECERR : (sel_q ? m1.rresp : m0.rresp);
	assign resp_rdata = decerr_q ? '0 : (sel_q ? m1.rdata : m0.rdata);
	assign resp_done = wr_q ? (resp_bvalid & win_bready) : (resp_rvalid & win_rready);

	assign s0.bvalid = resp_bvalid & ~win_q;
	assign s0.bresp = resp_bresp;
	assign s0.rvalid = resp_rvalid & ~win_q;
	assign s0.rdata = resp_rdata;
	assign s0.rresp = resp_rresp;
	assign s1.bvalid = resp_bvalid & win_q;
	assign s1.bresp = resp_bresp;
	assign s1.rvalid = resp_rvalid & win_q;
	assign s1.rdata = resp_rdata;
	assign s1.rresp = resp_rresp;

	assign m0.bready = (state == ST_RESP) & wr_q & ~decerr_q & ~sel_q & win_bready;
	assign m0.rready = (state == ST_RESP) & ~wr_q & ~decerr_q & ~sel_q & win_rready;
	assign m1.bready = (state == ST_RESP) & wr_q & ~decerr_q & sel_q & win_bready;
	assign m1.rready = (state == ST_RESP) & ~wr_q & ~decerr_q & sel_q & win_rready;

	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			state <= ST_IDLE;
			rr <= 1'b0;
			aw_pend <= 1'b0;
			w_pend <= 1'b0;
			ar_pend <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (grant) begin
						state <= ST_REQ;
						rr <= ~win;
						aw_pend <= win_wr & (hit_mem | hit_gfx);
						w_pend <= win_wr & (hit_mem | hit_gfx);
						ar_pend <= ~win_wr & (hit_mem | hit_gfx);
					end
				end
				ST_REQ: begin
					aw_pend <= aw_pend & ~aw_hs;
					w_pend <= w_pend & ~w_hs;
					ar_pend <= ar_pend & ~ar_hs;
					if (!req_left)
						state <= ST_RESP;
				end
				default: begin
					if (resp_done)
						state <= ST_IDLE; // Free on the next cycle
				end
			endcase
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (grant) begin
			addr_q <= win_addr;
			prot_q <= win_prot;
			data_q <= win ? s1.wdata : s0.wdata;
			strb_q <= win ? s1.wstrb : s0.wstrb;
			wr_q <= win_wr;
			win_q <= win;
			sel_q <= hit_gfx;
			decerr_q <= ~(hit_mem | hit_gfx);
		end
	end

endmodule

//--- verilog/axil_ram.sv
// Word-addressed AXI-Lite RAM with byte-masked writes
`timescale 1ns/1ps

module axil_ram #(
	parameter int DEPTH_WORDS = 1024
) (
	input logic hdmi_pixClk,
	input logic reset,
	axil_if.slave bus
);

	localparam int IDX_BITS = $clog2(DEPTH_WORDS);

	logic [soc_pkg::DATA_WIDTH-1:0] mem [DEPTH_WORDS];
	logic [soc_pkg::DATA_WIDTH-1:0] rdata_q;
	logic bvalid_q, rvalid_q;
	logic idle, wr_accept, rd_accept;
	logic [IDX_BITS-1:0] wr_idx, rd_idx;

	assign idle = ~bvalid_q & ~rvalid_q;
	assign wr_accept = idle & bus.awvalid & bus.wvalid;
	assign rd_accept = idle & bus.arvalid & ~wr_accept; // Writes first

	// Byte address to word index, wrapping at the array size
	assign wr_idx = IDX_BITS'((bus.awaddr >> 2) % DEPTH_WORDS);
	assign rd_idx = IDX_BITS'((bus.araddr >> 2) % DEPTH_WORDS);

	assign bus.awready = wr_accept;
	assign bus.wready = wr_accept;
	assign bus.arready = rd_accept;
	assign bus.bvalid = bvalid_q;
	assign bus.bresp = soc_pkg::RESP_OKAY;
	assign bus.rvalid = rvalid_q;
	assign bus.rdata = rdata_q;
	assign bus.rresp = soc_pkg::RESP_OKAY;

	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_accept)
				bvalid_q <= 1'b1;
			else if (bus.bready)
				bvalid_q <= 1'b0;
			if (rd_accept)
				rvalid_q <= 1'b1;
			else if (bus.rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (wr_accept) begin
			for (int b = 0; b < soc_pkg::STRB_WIDTH; b++) begin
				if (bus.wstrb[b])
					mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
			end
		end
		if (rd_accept)
			rdata_q <= mem[rd_idx];
	end

endmodule

//--- verilog/gfx_scanout.sv
// Graphics scanout with a register slave and a line-fetch master emitting pixel strobes
`timescale 1ns/1ps

module gfx_scanout (
	input logic hdmi_pixClk,
	input logic reset,
	axil_if.slave regs,
	axil_if.master fetch,
	output logic pix_valid,
	output logic [soc_pkg::DATA_WIDTH-1:0] pix_data
);

	localparam logic [1:0] F_IDLE = 2'd0;
	localparam logic [1:0] F_ADDR = 2'd1;
	localparam logic [1:0] F_DATA = 2'd2;

	logic [soc_pkg::DATA_WIDTH-1:0] ctrl, fb_base, line_words, frame_count;
	logic [soc_pkg::DATA_WIDTH-1:0] rdata_q, rd_word;
	logic bvalid_q, rvalid_q;
	logic idle, wr_accept, rd_accept;
	logic [soc_pkg::GFX_ADDR_BITS-1:0] wr_off, rd_off;

	logic [1:0] fstate;
	logic [soc_pkg::DATA_WIDTH-1:0] word_idx, line_len;
	logic [soc_pkg::ADDR_WIDTH-1:0] line_base;
	logic start_ok, last_word, r_hs, frame_start;

	function automatic logic [soc_pkg::DATA_WIDTH-1:0] merge_bytes(
		input logic [soc_pkg::DATA_WIDTH-1:0] old_word,
		input logic [soc_pkg::DATA_WIDTH-1:0] new_word,
		input logic [soc_pkg::STRB_WIDTH-1:0] strb
	);
		logic [soc_pkg::DATA_WIDTH-1:0] result;
		result = old_word;
		for (int b = 0; b < soc_pkg::STRB_WIDTH; b++) begin
			if (strb[b])
				result[8*b +: 8] = new_word[8*b +: 8];
		end
		return result;
	endfunction

	// Register slave, same timing as the RAM
	assign idle = ~bvalid_q & ~rvalid_q;
	assign wr_accept = idle & regs.awvalid & regs.wvalid;
	assign rd_accept = idle & regs.arvalid & ~wr_accept;
	assign wr_off = regs.awaddr[soc_pkg::GFX_ADDR_BITS-1:0];
	assign rd_off = regs.araddr[soc_pkg::GFX_ADDR_BITS-1:0];

	assign regs.awready = wr_accept;
	assign regs.wready = wr_accept;
	assign regs.arready = rd_accept;
	assign regs.bvalid = bvalid_q;
	assign regs.bresp = soc_pkg::RESP_OKAY;
	assign regs.rvalid = rvalid_q;
	assign regs.rdata = rdata_q;
	assign regs.rresp = soc_pkg::RESP_OKAY;

	always_comb begin
		case (rd_off)
			soc_pkg::REG_CTRL: rd_word = ctrl;
			soc_pkg::REG_FB_BASE: rd_word = fb_base;
			soc_pkg::REG_LINE_WORDS: rd_word = line_words;
			soc_pkg::REG_FRAME_COUNT: rd_word = frame_count;
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			ctrl <= '0;
			fb_base <= '0;
			line_words <= '0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_accept) begin
				bvalid_q <= 1'b1;
				case (wr_off)
					soc_pkg::REG_CTRL: ctrl <= merge_bytes(ctrl, regs.wdata, regs.wstrb);
					soc_pkg::REG_FB_BASE: fb_base <= merge_bytes(fb_base, regs.wdata, regs.wstrb);
					soc_pkg::REG_LINE_WORDS: begin
						line_words <= merge_bytes(line_words, regs.wdata, regs.wstrb);
					end
					default: ; // Frame counter and holes ignore writes
				endcase
			end else if (regs.bready) begin
				bvalid_q <= 1'b0;
			end
			if (rd_accept)
				rvalid_q <= 1'b1;
			else if (regs.rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (rd_accept)
			rdata_q <= rd_word;
	end

	// Line fetch, one read in flight
	assign start_ok = ctrl[soc_pkg::CTRL_ENABLE_BIT] & (line_words != '0);
	assign last_word = word_idx == line_len - 1'b1;
	assign r_hs = (fstate == F_DATA) & fetch.rvalid;
	assign frame_start = start_ok & ((fstate == F_IDLE) | (r_hs & last_word));

	assign fetch.araddr = line_base + (word_idx << 2);
	assign fetch.arprot = '0;
	assign fetch.arvalid = fstate == F_ADDR;
	assign fetch.rready = fstate == F_DATA;
	assign fetch.awaddr = '0; // Read-only master
	assign fetch.awprot = '0;
	assign fetch.awvalid = 1'b0;
	assign fetch.wdata = '0;
	assign fetch.wstrb = '0;
	assign fetch.wvalid = 1'b0;
	assign fetch.bready = 1'b0;

	always_ff @(posedge hdmi_pixClk) begin
		if (reset) begin
			fstate <= F_IDLE;
			word_idx <= '0;
			frame_count <= '0;
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= r_hs;
			case (fstate)
				F_IDLE: begin
					if (start_ok) begin
						fstate <= F_ADDR;
						word_idx <= '0;
					end
				end
				F_ADDR: begin
					if (fetch.arready)
						fstate <= F_DATA;
				end
				default: begin
					if (fetch.rvalid) begin
						if (last_word) begin
							frame_count <= frame_count + 1'b1;
							word_idx <= '0;
							fstate <= start_ok ? F_ADDR : F_IDLE;
						end else begin
							word_idx <= word_idx + 1'b1;
							fstate <= F_ADDR;
						end
					end
				end
			endcase
		end
	end

	// Base and length held for a whole line
	always_ff @(posedge hdmi_pixClk) begin
		if (frame_start) begin
			line_base <= fb_base;
			line_len <= line_words;
		end
		if (r_hs)
			pix_data <= fetch.rdata;
	end

endmodule

//--- verilog/gfx_soc.sv
// Graphics SoC top joining the external bus port, interconnect, RAM and scanout engine
`timescale 1ns/1ps

module gfx_soc #(
	parameter int MEM_DEPTH_WORDS = 1024
) (
	input logic hdmi_pixClk,
	input logic reset,
	input logic [soc_pkg::ADDR_WIDTH-1:0] s_axil_awaddr,
	input logic [soc_pkg::PROT_WIDTH-1:0] s_axil_awprot,
	input logic s_axil_awvalid,
	output logic s_axil_awready,
	input logic [soc_pkg::DATA_WIDTH-1:0] s_axil_wdata,
	input logic [soc_pkg::STRB_WIDTH-1:0] s_axil_wstrb,
	input logic s_axil_wvalid,
	output logic s_axil_wready,
	output logic [1:0] s_axil_bresp,
	output logic s_axil_bvalid,
	input logic s_axil_bready,
	input logic [soc_pkg::ADDR_WIDTH-1:0] s_axil_araddr,
	input logic [soc_pkg::PROT_WIDTH-1:0] s_axil_arprot,
	input logic s_axil_arvalid,
	output logic s_axil_arready,
	output logic [soc_pkg::DATA_WIDTH-1:0] s_axil_rdata,
	output logic [1:0] s_axil_rresp,
	output logic s_axil_rvalid,
	input logic s_axil_rready,
	output logic pix_valid,
	output logic [soc_pkg::DATA_WIDTH-1:0] pix_data
);

	axil_if ext_bus ();
	axil_if scan_bus ();
	axil_if mem_bus ();
	axil_if gfx_bus ();

	// External master port
	assign ext_bus.awaddr = s_axil_awaddr;
	assign ext_bus.awprot = s_axil_awprot;
	assign ext_bus.awvalid = s_axil_awvalid;
	assign s_axil_awready = ext_bus.awready;
	assign ext_bus.wdata = s_axil_wdata;
	assign ext_bus.wstrb = s_axil_wstrb;
	assign ext_bus.wvalid = s_axil_wvalid;
	assign s_axil_wready = ext_bus.wready;
	assign s_axil_bresp = ext_bus.bresp;
	assign s_axil_bvalid = ext_bus.bvalid;
	assign ext_bus.bready = s_axil_bready;
	assign ext_bus.araddr = s_axil_araddr;
	assign ext_bus.arprot = s_axil_arprot;
	assign ext_bus.arvalid = s_axil_arvalid;
	assign s_axil_arready = ext_bus.arready;
	assign s_axil_rdata = ext_bus.rdata;
	assign s_axil_rresp = ext_bus.rresp;
	assign s_axil_rvalid = ext_bus.rvalid;
	assign ext_bus.rready = s_axil_rready;

	axil_interconnect xbar_i (
		.hdmi_pixClk(hdmi_pixClk),
		.reset(reset),
		.s0(ext_bus),
		.s1(scan_bus),
		.m0(mem_bus),
		.m1(gfx_bus)
	);

	axil_ram #(
		.DEPTH_WORDS(MEM_DEPTH_WORDS)
	) ram_i (
		.hdmi_pixClk(hdmi_pixClk),
		.reset(reset),
		.bus(mem_bus)
	);

	gfx_scanout scan_i (
		.hdmi_pixClk(hdmi_pixClk),
		.reset(reset),
		.regs(gfx_bus),
		.fetch(scan_bus),
		.pix_valid(pix_valid),
		.pix_data(pix_data)
	);

endmodule

//--- tests/gfx_soc_sva.sv
// Protocol assertions on the graphics SoC bus links and pixel strobe, attached with bind
`timescale 1ns/1ps

module gfx_soc_sva (
	input logic hdmi_pixClk,
	input logic reset,
	input logic [soc_pkg::ADDR_WIDTH-1:0] s_axil_awaddr,
	input logic s_axil_awvalid,
	input logic s_axil_awready,
	input logic [1:0] s_axil_bresp,
	input logic s_axil_bvalid,
	input logic s_axil_bready,
	input logic s_axil_rvalid,
	input logic s_axil_rready,
	input logic mem_awvalid,
	input logic mem_awready,
	input logic mem_wvalid,
	input logic mem_wready,
	input logic scan_arvalid,
	input logic scan_arready,
	input logic pix_valid
);

	logic [soc_pkg::ADDR_WIDTH-1:0] aw_addr_q; // Address of the write in flight
	logic in_ram;

	assign in_ram = (aw_addr_q >> soc_pkg::MEM_ADDR_BITS) ==
		(soc_pkg::MEM_BASE >> soc_pkg::MEM_ADDR_BITS);

	always @(posedge hdmi_pixClk) begin
		if (s_axil_awvalid && s_axil_awready)
			aw_addr_q <= s_axil_awaddr;
	end

	// Interconnect to RAM, and scanout fetch master
	assert property (@(posedge hdmi_pixClk) disable iff (reset)
		mem_awvalid && !mem_awready |=> mem_awvalid)
		else $error("awvalid to the RAM dropped before its handshake");
	assert property (@(posedge hdmi_pixClk) disable iff (reset)
		mem_wvalid && !mem_wready |=> mem_wvalid)
		else $error("wvalid to the RAM dropped before its handshake");
	assert property (@(posedge hdmi_pixClk) disable iff (reset)
		scan_arvalid && !scan_arready |=> scan_arvalid)
		else $error("scanout arvalid dropped before its handshake");
	assert property (@(posedge hdmi_pixClk) disable iff (reset)
		s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
		else $error("bvalid dropped before its handshake");
	assert property (@(posedge hdmi_pixClk) disable iff (reset)
		s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
		else $error("rvalid dropped before its handshake");
	assert property (@(posedge hdmi_pixClk)
		reset && $past(reset) |-> !pix_valid && !s_axil_bvalid && !s_axil_rvalid)
		else $error("pixel strobe or response valid high during reset");
	assert property (@(posedge hdmi_pixClk) disable iff (reset)
		s_axil_bvalid && in_ram |-> s_axil_bresp != soc_pkg::RESP_DECERR)
		else $error("decode error on a write inside the RAM window");

endmodule

bind gfx_soc gfx_soc_sva sva_i (
	.hdmi_pixClk(hdmi_pixClk),
	.reset(reset),
	.s_axil_awaddr(s_axil_awaddr),
	.s_axil_awvalid(s_axil_awvalid),
	.s_axil_awready(s_axil_awready),
	.s_axil_bresp(s_axil_bresp),
	.s_axil_bvalid(s_axil_bvalid),
	.s_axil_bready(s_axil_bready),
	.s_axil_rvalid(s_axil_rvalid),
	.s_axil_rready(s_axil_rready),
	.mem_awvalid(mem_bus.awvalid),
	.mem_awready(mem_bus.awready),
	.mem_wvalid(mem_bus.wvalid),
	.mem_wready(mem_bus.wready),
	.scan_arvalid(scan_bus.arvalid),
	.scan_arready(scan_bus.arready),
	.pix_valid(pix_valid)
);

//--- tests/gfx_soc_tb.sv
// Testbench for the graphics SoC with random bus traffic, a memory model and a scanout model
`timescale 1ns/1ps

module gfx_soc_tb;

	localparam int MEM_WORDS = 1024;
	localparam int FB_IDX = 512; // Framebuffer word index, above the random traffic
	localparam int OP_LIMIT = 300; // Bus operations over all phases stay below this
	localparam int OP_CYCLES = 30; // Arbitration wait, three-cycle transfer, ready delay
	localparam int SCAN_CYCLES = 3 * 12 * OP_CYCLES;
	localparam int MAX_CYCLES = 10 + OP_LIMIT * OP_CYCLES + SCAN_CYCLES;

	logic hdmi_pixClk;
	logic reset;
	logic [soc_pkg::ADDR_WIDTH-1:0] s_axil_awaddr, s_axil_araddr;
	logic [soc_pkg::PROT_WIDTH-1:0] s_axil_awprot, s_axil_arprot;
	logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
	logic [soc_pkg::DATA_WIDTH-1:0] s_axil_wdata, s_axil_rdata;
	logic [soc_pkg::STRB_WIDTH-1:0] s_axil_wstrb;
	logic [1:0] s_axil_bresp, s_axil_rresp;
	logic s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
	logic s_axil_rvalid, s_axil_rready;
	logic pix_valid;
	logic [soc_pkg::DATA_WIDTH-1:0] pix_data;

	integer seed;
	logic [31:0] mem_model [int]; // Keyed by word index
	int written [$];
	int pix_count = 0;
	int line_len = 1;
	int cycles = 0;
	logic scan_armed = 1'b0;

	gfx_soc #(
		.MEM_DEPTH_WORDS(MEM_WORDS)
	) dut_i (
		.*
	);

	initial hdmi_pixClk = 1'b0;
	always #50 hdmi_pixClk = ~hdmi_pixClk;

	task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("FAIL %0d ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] gfx_reg_addr(input logic [7:0] off);
		return soc_pkg::GFX_BASE | 32'(off);
	endfunction

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int delay;
		logic aw_done, w_done, done;
		delay = $random(seed) & 3;
		@(posedge hdmi_pixClk);
		s_axil_awaddr <= addr;
		s_axil_wdata <= data;
		s_axil_wstrb <= strb;
		s_axil_awvalid <= 1'b1;
		s_axil_wvalid <= 1'b1;
		aw_done = 1'b0;
		w_done = 1'b0;
		while (!(aw_done && w_done)) begin
			@(posedge hdmi_pixClk);
			if (!aw_done && s_axil_awready) begin
				aw_done = 1'b1;
				s_axil_awvalid <= 1'b0;
			end
			if (!w_done && s_axil_wready) begin
				w_done = 1'b1;
				s_axil_wvalid <= 1'b0;
			end
		end
		done = 1'b0;
		while (!done) begin
			if (delay == 0)
				s_axil_bready <= 1'b1;
			else
				delay--;
			@(posedge hdmi_pixClk);
			done = s_axil_bvalid & s_axil_bready;
		end
		resp = s_axil_bresp;
		s_axil_bready <= 1'b0;
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int delay;
		logic done;
		delay = $random(seed) & 3;
		@(posedge hdmi_pixClk);
		s_axil_araddr <= addr;
		s_axil_arvalid <= 1'b1;
		@(posedge hdmi_pixClk);
		while (!s_axil_arready)
			@(posedge hdmi_pixClk);
		s_axil_arvalid <= 1'b0;
		done = 1'b0;
		while (!done) begin
			if (delay == 0)
				s_axil_rready <= 1'b1;
			else
				delay--;
			@(posedge hdmi_pixClk);
			done = s_axil_rvalid & s_axil_rready;
		end
		data = s_axil_rdata;
		resp = s_axil_rresp;
		s_axil_rready <= 1'b0;
	endtask

	task automatic write_okay(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [1:0] resp;
		bus_write(addr, data, strb, resp);
		compare_word(32'(resp), 32'(soc_pkg::RESP_OKAY), "write response");
	endtask

	task automatic read_compare(input logic [31:0] addr, input logic [31:0] exp,
		input string what);
		logic [31:0] data;
		logic [1:0] resp;
		bus_read(addr, data, resp);
		compare_word(32'(resp), 32'(soc_pkg::RESP_OKAY), "read response");
		compare_word(data, exp, what);
	endtask

	task automatic ram_write_random(input int idx);
		logic [31:0] data;
		data = $random(seed);
		write_okay(32'(idx) << 2, data, 4'hf);
		if (!mem_model.exists(idx))
			written.push_back(idx);
		mem_model[idx] = data;
	endtask

	// Scanout model, one model word per strobe, line repeated every frame
	always @(posedge hdmi_pixClk) begin
		if (!reset && pix_valid) begin
			if (!scan_armed)
				compare_word(32'(pix_valid), 32'h0, "pixel strobe while scanout disabled");
			compare_word(pix_data, mem_model[FB_IDX + pix_count % line_len], "pixel word");
			pix_count = pix_count + 1;
		end
	end

	always @(posedge hdmi_pixClk) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	end

	initial begin
		logic [1:0] resp;
		logic [31:0] data, addr, word, ctrl_v, base_v, lw_v;
		logic [3:0] strb;
		int idx;
		int quiet;
		seed = 32'hd1a1_ee1e;
		reset = 1'b1;
		s_axil_awaddr = '0;
		s_axil_awprot = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_wstrb = '0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b0;
		s_axil_araddr = '0;
		s_axil_arprot = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b0;
		repeat (10) @(posedge hdmi_pixClk);
		reset <= 1'b0;

		// Full-word writes then read-back
		for (int i = 0; i < 32; i++)
			ram_write_random($unsigned($random(seed)) % 256);
		foreach (written[i])
			read_compare(32'(written[i]) << 2, mem_model[written[i]], "RAM read-back");

		for (int i = 0; i < 16; i++) begin
			idx = written[$unsigned($random(seed)) % written.size()];
			data = $random(seed);
			word = $random(seed);
			strb = word[3:0];
			write_okay(32'(idx) << 2, data, strb);
			word = mem_model[idx];
			for (int b = 0; b < 4; b++) begin
				if (strb[b])
					word[8*b +: 8] = data[8*b +: 8];
			end
			mem_model[idx] = word;
			read_compare(32'(idx) << 2, word, "byte-masked word");
		end

		for (int i = 0; i < 4; i++) begin
			ctrl_v = $random(seed);
			ctrl_v[soc_pkg::CTRL_ENABLE_BIT] = 1'b0; // No scanout yet
			base_v = $random(seed);
			lw_v = $random(seed);
			write_okay(gfx_reg_addr(soc_pkg::REG_CTRL), ctrl_v, 4'hf);
			write_okay(gfx_reg_addr(soc_pkg::REG_FB_BASE), base_v, 4'hf);
			write_okay(gfx_reg_addr(soc_pkg::REG_LINE_WORDS), lw_v, 4'hf);
			write_okay(gfx_reg_addr(soc_pkg::REG_FRAME_COUNT), $random(seed), 4'hf);
			read_compare(gfx_reg_addr(soc_pkg::REG_CTRL), ctrl_v, "control register");
			read_compare(gfx_reg_addr(soc_pkg::REG_FB_BASE), base_v, "base register");
			read_compare(gfx_reg_addr(soc_pkg::REG_LINE_WORDS), lw_v, "line-words register");
			read_compare(gfx_reg_addr(soc_pkg::REG_FRAME_COUNT), 32'h0, "idle frame count");
			read_compare(gfx_reg_addr(8'h10 + 8'(4 * i)), 32'h0, "unused register offset");
			read_compare(gfx_reg_addr(8'hfc), 32'h0, "last register offset");
		end

		// Unmapped addresses, upper nibble 4 hits neither window, low bits alias a RAM word
		for (int i = 0; i < 8; i++) begin
			idx = written[$unsigned($random(seed)) % written.size()];
			addr = 32'h4000_0000 | ($random(seed) & 32'h0ffc_0000) | (32'(idx) << 2);
			bus_write(addr, $random(seed), 4'hf, resp);
			compare_word(32'(resp), 32'(soc_pkg::RESP_DECERR), "unmapped write response");
			bus_read(addr, data, resp);
			compare_word(32'(resp), 32'(soc_pkg::RESP_DECERR), "unmapped read response");
			compare_word(data, 32'h0, "unmapped read data");
		end
		foreach (written[i])
			read_compare(32'(written[i]) << 2, mem_model[written[i]], "RAM after decode errors");

		line_len = 4 + $unsigned($random(seed)) % 9;
		for (int k = 0; k < line_len; k++) begin
			data = $random(seed);
			write_okay(32'(FB_IDX + k) << 2, data, 4'hf);
			mem_model[FB_IDX + k] = data;
		end
		write_okay(gfx_reg_addr(soc_pkg::REG_FB_BASE), 32'(FB_IDX) << 2, 4'hf);
		write_okay(gfx_reg_addr(soc_pkg::REG_LINE_WORDS), 32'(line_len), 4'hf);
		scan_armed = 1'b1;
		write_okay(gfx_reg_addr(soc_pkg::REG_CTRL), 32'h1 << soc_pkg::CTRL_ENABLE_BIT, 4'hf);

		// RAM traffic below the framebuffer while lines are fetched
		for (int i = 0; i < 24; i++) begin
			word = $random(seed);
			if (word[0]) begin
				ram_write_random($unsigned($random(seed)) % 256);
			end else begin
				idx = written[$unsigned($random(seed)) % written.size()];
				read_compare(32'(idx) << 2, mem_model[idx], "RAM during scanout");
			end
		end
		while (pix_count < 2 * line_len)
			@(posedge hdmi_pixClk);
		write_okay(gfx_reg_addr(soc_pkg::REG_CTRL), 32'h0, 4'hf);

		quiet = 0; // Current line drains, then no more strobes
		while (quiet < 20) begin
			@(posedge hdmi_pixClk);
			if (pix_valid)
				quiet = 0;
			else
				quiet++;
		end
		compare_word(32'(pix_count % line_len), 32'h0, "pixels beyond the last full line");
		read_compare(gfx_reg_addr(soc_pkg::REG_FRAME_COUNT), 32'(pix_count / line_len),
			"frame count");

		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- verilog.f
verilog/soc_pkg.sv
verilog/axil_if.sv
verilog/axil_interconnect.sv
verilog/axil_ram.sv
verilog/gfx_scanout.sv
verilog/gfx_soc.sv
tests/gfx_soc_sva.sv
tests/gfx_soc_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module gfx_soc_tb -f verilog.f \
	-o gfx_soc_sim > build.log 2>&1 &&
./obj_dir/gfx_soc_sim > sim.log 2>&1
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "No pass result, see build.log and sim.log"; exit 1; }
echo "Simulation passed"
